// File: hdl/data_mem.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module data_mem (
	input  logic                 clk,
	input  logic                 we, // Write strobe
	input  mem_seq_pkg::addr_t   addr,
	input  mem_seq_pkg::word_t   wdata,
	output mem_seq_pkg::word_t   rdata // Valid READ_LAT cycles after addr
);
	import mem_seq_pkg::*;

	word_t mem [`MEM_DEPTH]; // Contents not reset
	addr_t addr_q; // First read stage
	word_t rd_pipe [`READ_LAT-1]; // Remaining read stages

	////////////////////
	// Write port

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	////////////////////
	// Read pipeline

	always_ff @(posedge clk) begin
		addr_q     <= addr; // Registered address
		rd_pipe[0] <= mem[addr_q]; // Registered output
		for (int i = 1; i < `READ_LAT - 1; i++) begin
			rd_pipe[i] <= rd_pipe[i-1]; // Extra stages if latency grows
		end
	end

	assign rdata = rd_pipe[`READ_LAT-2];

	// A write to an unknown address corrupts the memory
	assert property (@(posedge clk) we |-> !$isunknown(addr));

endmodule

// File: hdl/lane_regs.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module lane_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  mem_seq_pkg::lane_mask_t  we, // Per-lane write enables
	input  mem_seq_pkg::word_t       wdata, // Memory read data
	output mem_seq_pkg::word_t       dr [`MEM_LANES] // Lane data registers
);

	////////////////////
	// Lane data registers

	// Several lanes load together on a common load
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `MEM_LANES; i++) begin
				dr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `MEM_LANES; i++) begin
				if (we[i]) begin
					dr[i] <= wdata; // Same edge as enable
				end
			end
		end
	end

endmodule

// File: hdl/lane_select.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module lane_select #(
	parameter type payload_t = logic // Address or data word
) (
	input  logic                clk,
	input  logic                rst_n,
	input  payload_t            lanes [`MEM_LANES], // One value per lane
	input  mem_seq_pkg::lane_t  lane_sel,
	output payload_t            sel
);

	// Plain mux onto the single memory port
	assign sel = lanes[lane_sel];

	// An unknown index would feed X to the memory
	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(lane_sel));

endmodule

// File: hdl/mem_seq_fsm.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module mem_seq_fsm (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cyc, // Wishbone cycle
	input  logic                     stb, // Wishbone strobe
	input  mem_seq_pkg::mem_op_t     op, // Requested operation
	input  mem_seq_pkg::step_t       step, // Step within operation
	input  logic                     last, // Final step flag
	output logic                     run, // Advance step counter
	output logic                     clear, // Hold step counter at zero
	output mem_seq_pkg::mem_op_t     op_q, // Latched operation
	output mem_seq_pkg::lane_t       lane_sel, // Address and data lane
	output logic                     mem_we, // Data memory write
	output mem_seq_pkg::lane_mask_t  dr_we, // Lane register writes
	output logic                     ack // Wishbone ack
);
	import mem_seq_pkg::*;

	typedef enum logic [1:0] {
		idle   = 2'd0,
		busy   = 2'd1,
		ack_st = 2'd2
	} state_t;

	state_t state;

	////////////////////
	// State register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			op_q  <= op_none;
		end else begin
			case (state)
				idle: begin
					if (cyc && stb) begin // Request accepted here
						op_q  <= op;
						state <= (op == op_none) ? ack_st : busy; // Nothing to run
					end
				end
				busy: begin
					if (last) begin
						state <= ack_st; // Results settle this edge
					end
				end
				ack_st: begin
					state <= idle; // Ack is a single cycle
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	////////////////////
	// Strobe decode

	always_comb begin
		run      = 1'b0;
		clear    = 1'b0;
		lane_sel = '0; // Lane 0 unless a step says otherwise
		mem_we   = 1'b0;
		dr_we    = '0;
		case (state)
			idle: begin
				clear = 1'b1; // Counter starts at step 0
			end
			busy: begin
				run = 1'b1;
				case (op_q)
					op_common: begin
						dr_we = {`MEM_LANES{last}}; // Broadcast once data is out
					end
					op_diff: begin
						lane_sel = lane_t'(step / `STEPS_PER_LANE); // Three steps per lane
						if ((step % `STEPS_PER_LANE) == (`STEPS_PER_LANE - 1)) begin
							dr_we[lane_sel] = 1'b1; // Read data valid now
						end
					end
					op_store: begin
						lane_sel = lane_t'(step); // One lane per step
						mem_we   = 1'b1;
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

	assign ack = (state == ack_st);

	////////////////////
	// Checks

	// Write and read-back never share the memory port
	assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && (|dr_we)));

	// Master must see one ack per request
	assert property (@(posedge clk) disable iff (!rst_n) ack |=> !ack);

	// Common load writes all lanes together once read data is out
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == busy && op_q == op_common)
			|-> (dr_we == {`MEM_LANES{step == step_t'(`READ_LAT)}}));

endmodule

// File: hdl/mem_seq_pkg.sv
`include "mem_seq_settings.svh"

package mem_seq_pkg;

	////////////////////
	// Request operation

	typedef enum logic [1:0] {
		op_none   = 2'd0, // Ack only, nothing touched
		op_common = 2'd1, // Lane 0 address broadcast to all lanes
		op_diff   = 2'd2, // Each lane loads its own address
		op_store  = 2'd3  // Each lane stores its own word
	} mem_op_t;

	////////////////////
	// Payload and control types

	typedef logic [`ADDR_W-1:0] addr_t; // Memory word address
	typedef logic [`WORD_W-1:0] word_t; // Memory and lane data
	typedef logic [$clog2(`MEM_LANES)-1:0] lane_t; // Lane index
	typedef logic [`MEM_LANES-1:0] lane_mask_t; // One bit per lane

	// Longest operation is the per-lane load at 12 steps
	typedef logic [3:0] step_t;

endpackage

// File: hdl/mem_seq_settings.svh
`ifndef MEM_SEQ_SETTINGS_SVH
`define MEM_SEQ_SETTINGS_SVH

////////////////////
// Lane geometry
`define MEM_LANES 4 // SIMD lanes served by the sequencer

////////////////////
// Data memory
`define ADDR_W 8 // Word address bits
`define WORD_W 16 // Data word bits
`define MEM_DEPTH (1 << `ADDR_W) // Words held in the memory
`define READ_LAT 2 // Address reg plus output reg

// A per-lane load waits out the read latency, then writes in one more cycle
`define STEPS_PER_LANE (`READ_LAT + 1)

`endif

// File: hdl/mem_seq_top.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module mem_seq_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cyc, // Wishbone cycle
	input  logic                  stb, // Wishbone strobe
	input  mem_seq_pkg::mem_op_t  op, // Requested operation
	input  mem_seq_pkg::addr_t    ar [`MEM_LANES], // Lane address registers
	input  mem_seq_pkg::word_t    d [`MEM_LANES], // Lane store data
	output logic                  ack, // Wishbone ack
	output mem_seq_pkg::word_t    dr [`MEM_LANES] // Lane data registers
);
	import mem_seq_pkg::*;

	mem_op_t    op_q; // Latched operation
	step_t      step;
	logic       last;
	logic       run;
	logic       clear;
	lane_t      lane_sel; // Shared by both selectors
	logic       mem_we;
	lane_mask_t dr_we;
	addr_t      mem_addr;
	word_t      mem_wdata;
	word_t      rdata;

	////////////////////
	// Control

	mem_seq_fsm mem_seq_fsm_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cyc      (cyc),
		.stb      (stb),
		.op       (op),
		.step     (step),
		.last     (last),
		.run      (run),
		.clear    (clear),
		.op_q     (op_q),
		.lane_sel (lane_sel),
		.mem_we   (mem_we),
		.dr_we    (dr_we),
		.ack      (ack)
	);

	step_counter step_counter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.clear (clear),
		.run   (run),
		.op    (op_q), // Operation held for whole request
		.step  (step),
		.last  (last)
	);

	////////////////////
	// Datapath

	lane_select #(.payload_t(addr_t)) addr_sel_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.lanes    (ar),
		.lane_sel (lane_sel),
		.sel      (mem_addr)
	);

	lane_select #(.payload_t(word_t)) data_sel_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.lanes    (d),
		.lane_sel (lane_sel),
		.sel      (mem_wdata)
	);

	data_mem data_mem_i (
		.clk   (clk),
		.we    (mem_we),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (rdata)
	);

	lane_regs lane_regs_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (dr_we),
		.wdata (rdata),
		.dr    (dr)
	);

endmodule

// File: hdl/step_counter.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module step_counter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  clear, // Return to step 0
	input  logic                  run, // Operation in progress
	input  mem_seq_pkg::mem_op_t  op, // Latched operation
	output mem_seq_pkg::step_t    step,
	output logic                  last // Final step of op
);
	import mem_seq_pkg::*;

	localparam step_t LAST_COMMON = step_t'(`READ_LAT); // Data out after latency
	localparam step_t LAST_DIFF   = step_t'(`MEM_LANES * `STEPS_PER_LANE - 1);
	localparam step_t LAST_STORE  = step_t'(`MEM_LANES - 1); // One write per lane

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			step <= '0;
		end else if (run && !last) begin
			step <= step + step_t'(1); // Holds on final step
		end
	end

	// Final step per operation
	always_comb begin
		case (op)
			op_common: last = (step == LAST_COMMON);
			op_diff:   last = (step == LAST_DIFF);
			op_store:  last = (step == LAST_STORE);
			default:   last = 1'b0; // op_none never runs
		endcase
	end

	// Counter stays inside the longest operation
	assert property (@(posedge clk) disable iff (!rst_n) step <= LAST_DIFF);

endmodule

// File: project.f
+incdir+hdl
hdl/mem_seq_pkg.sv
hdl/mem_seq_fsm.sv
hdl/step_counter.sv
hdl/lane_select.sv
hdl/data_mem.sv
hdl/lane_regs.sv
hdl/mem_seq_top.sv
tests/mem_seq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module mem_seq_tb \
	-o mem_seq_sim > build.log 2>&1 \
	&& ./obj_dir/mem_seq_sim > "$LOG" 2>&1 \
	|| { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat "$LOG"
grep -q "SIMULATION FAILED" "$LOG" && exit 1
exit 0

// File: tests/mem_seq_tb.sv
`timescale 1ns/1ns
`include "mem_seq_settings.svh"

module mem_seq_tb;
	import mem_seq_pkg::*;

	localparam int CLK_PERIOD = 8; // ns
	localparam int RESET_CYCLES = 16;
	localparam int N_REQUESTS = 10; // Total over all tests
	localparam int CYCLES_PER_REQUEST = 64; // Generous bound per request
	localparam int WATCHDOG_TIME = (RESET_CYCLES + CYCLES_PER_REQUEST * N_REQUESTS) * CLK_PERIOD;

	logic    clk;
	logic    rst_n;
	logic    cyc;
	logic    stb;
	mem_op_t op;
	addr_t   ar [`MEM_LANES]; // Lane address registers
	word_t   d [`MEM_LANES]; // Lane store data
	logic    ack;
	word_t   dr [`MEM_LANES]; // Lane data registers from DUT

	word_t   dr_at_ack [`MEM_LANES]; // dr sampled while ack high
	word_t   model_mem [`MEM_DEPTH]; // Written by stores only
	integer  seed;
	integer  errors;
	integer  checks;

	mem_seq_top mem_seq_top_i (
		.clk   (clk),
		.rst_n (rst_n),
		.cyc   (cyc),
		.stb   (stb),
		.op    (op),
		.ar    (ar),
		.d     (d),
		.ack   (ack),
		.dr    (dr)
	);

	////////////////////
	// Clock and watchdog

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_TIME);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////
	// Compare tasks

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ack_cycles(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_op_done(input string name, input bit got, input bit exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////
	// Expected behavior

	// Busy cycles per op, then one ack cycle
	function automatic int expected_ack_cycles(input mem_op_t req_op);
		int busy_cycles;
		case (req_op)
			op_common: busy_cycles = `READ_LAT + 1; // Address, wait, broadcast
			op_diff:   busy_cycles = `MEM_LANES * `STEPS_PER_LANE;
			op_store:  busy_cycles = `MEM_LANES; // One write per lane
			default:   busy_cycles = 0;
		endcase
		return busy_cycles + 1;
	endfunction

	// Lanes write in order 0 to 3, so the last lane wins a shared address
	task automatic apply_store_to_model();
		int k;
		for (k = 0; k < `MEM_LANES; k++) begin
			model_mem[ar[k]] = d[k];
		end
	endtask

	////////////////////
	// Wishbone driver

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Called on a falling edge, returns on the falling edge inside the ack cycle
	task automatic do_request(input mem_op_t req_op, output int n_cycles, output bit got_ack);
		int limit;
		int k;
		limit = expected_ack_cycles(req_op);
		n_cycles = 0;
		got_ack = 1'b0;
		op = req_op;
		cyc = 1'b1;
		stb = 1'b1;
		while (!got_ack && n_cycles < limit) begin
			@(negedge clk); // ack stable mid-cycle
			n_cycles++;
			got_ack = ack;
		end
		if (!got_ack) begin
			errors++;
			$display("No ack for %s request within %0d cycles at %0t ns",
				req_op.name(), limit, $time);
		end
		for (k = 0; k < `MEM_LANES; k++) begin
			dr_at_ack[k] = dr[k]; // Results valid with ack
		end
		cyc = 1'b0; // Bus released in the ack cycle
		stb = 1'b0;
	endtask

	task automatic request_checked(input mem_op_t req_op);
		int n_cycles;
		bit got_ack;
		do_request(req_op, n_cycles, got_ack);
		check_op_done({req_op.name(), " ack"}, got_ack, 1'b1);
		check_ack_cycles({req_op.name(), " ack cycles"}, n_cycles, expected_ack_cycles(req_op));
	endtask

	// Distinct addresses so every lane keeps its own word
	task automatic randomize_lanes();
		int k;
		int j;
		bit unique_ok;
		addr_t cand;
		for (k = 0; k < `MEM_LANES; k++) begin
			unique_ok = 1'b0;
			while (!unique_ok) begin
				cand = addr_t'($random(seed));
				unique_ok = 1'b1;
				for (j = 0; j < k; j++) begin
					if (ar[j] == cand) begin
						unique_ok = 1'b0;
					end
				end
			end
			ar[k] = cand;
			d[k] = word_t'($random(seed));
		end
	endtask

	task automatic check_diff_result();
		int k;
		for (k = 0; k < `MEM_LANES; k++) begin
			check_word($sformatf("dr[%0d]", k), dr_at_ack[k], model_mem[ar[k]]);
		end
	endtask

	task automatic check_common_result();
		int k;
		for (k = 0; k < `MEM_LANES; k++) begin
			check_word($sformatf("dr[%0d]", k), dr_at_ack[k], model_mem[ar[0]]);
		end
	endtask

	////////////////////
	// Directed tests

	task automatic test_reset_state();
		int k;
		check_op_done("ack after reset", ack, 1'b0);
		for (k = 0; k < `MEM_LANES; k++) begin
			check_word($sformatf("dr[%0d] after reset", k), dr[k], '0);
		end
	endtask

	task automatic test_store_then_diff();
		randomize_lanes();
		request_checked(op_store);
		apply_store_to_model();
		idle_cycles(2);
		request_checked(op_diff); // Same addresses as the store
		check_diff_result();
		idle_cycles(2);
	endtask

	task automatic test_common_broadcast();
		ar[0] = ar[2]; // Address written by the previous store
		ar[1] = addr_t'($random(seed)); // Ignored by a common load
		request_checked(op_common);
		check_common_result();
		idle_cycles(2);
	endtask

	task automatic test_shared_store_and_none();
		int k;
		addr_t shared;
		shared = addr_t'($random(seed));
		for (k = 0; k < `MEM_LANES; k++) begin
			ar[k] = shared;
			d[k] = word_t'($random(seed));
		end
		request_checked(op_store);
		apply_store_to_model();
		idle_cycles(2);
		request_checked(op_common);
		check_common_result(); // Lane 3 data expected
		check_word("shared word", dr_at_ack[`MEM_LANES-1], d[`MEM_LANES-1]);
		idle_cycles(2);
		request_checked(op_none);
		for (k = 0; k < `MEM_LANES; k++) begin
			check_word($sformatf("dr[%0d] after none", k), dr_at_ack[k], d[`MEM_LANES-1]);
		end
		idle_cycles(2);
	endtask

	// stb comes back one cycle after each ack
	task automatic test_back_to_back();
		randomize_lanes();
		request_checked(op_store);
		apply_store_to_model();
		@(negedge clk);
		request_checked(op_diff);
		check_diff_result();
		@(negedge clk);
		ar[0] = ar[3];
		request_checked(op_common);
		check_common_result();
		@(negedge clk);
		request_checked(op_none);
		check_common_result(); // Left as the common load set them
		idle_cycles(2);
	endtask

	////////////////////
	// Main sequence

	initial begin
		seed = 20;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		op = op_none;
		for (int k = 0; k < `MEM_LANES; k++) begin
			ar[k] = '0;
			d[k] = '0;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1; // Released on a falling edge
		@(negedge clk);

		test_reset_state();
		test_store_then_diff();
		test_common_broadcast();
		test_shared_store_and_none();
		test_back_to_back();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
